// ==== bench/tb_rv_back.sv ====
////////////////////
// Testbench for the RV32I back end
// Random instructions from a 16-bit LFSR with seed 98
// Memory model of 256 words
// Address bit 10 gives a bus error
// Expected results come from a shadow register file and memory
////////////////////

`timescale 1ns/1ns

`include "rv_back_consts.svh"

module tb_rv_back;

  localparam int NUM_TESTS = 6;

  // Expected outcome of one instruction
  typedef struct packed {
    logic [31:0]           pc;
    rv_trap_pkg::exc_vec_t exc;
    logic [31:0]           addr;
    logic                  we;
    logic [4:0]            dst;
    logic [31:0]           val;
    logic                  req;
  } exp_t;

  logic clk_i;
  logic rst_ni;
  logic [31:0] ex_pc_i, ex_instr_i, ex_r_i, ex_rs2_i;
  logic ex_bubble_i;
  logic stall_o;
  logic dmem_req_o, dmem_we_o, dmem_ack_i, dmem_err_i;
  logic [31:0] dmem_adr_o, dmem_d_o, dmem_q_i;
  logic [3:0] dmem_be_o;
  logic [4:0] rf_raddr_a_i, rf_raddr_b_i;
  logic [31:0] rf_rdata_a_o, rf_rdata_b_o, wb_pc_o, wb_badaddr_o;
  rv_trap_pkg::exc_vec_t wb_exception_o;

  // Bench state
  logic [15:0] lfsr_state;
  exp_t        exp_q [$];
  logic [31:0] sregs [`RV_NREGS];
  logic [31:0] smem [256];
  logic [31:0] resp_mem [256];
  logic [31:0] next_pc, chk_val;
  logic        advanced, mem_valid, ex_valid, chk_pending, busy;
  logic [1:0]  wait_left;
  int          cur_test, to_issue, errors, retired;

  rv_back_top u_rv_back_top (.*);

  always #10 clk_i = ~clk_i;

  ////////////////////
  // Helpers
  ////////////////////

  // Taps 16,14,13,11
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  // Initial contents mix all index bits
  function automatic logic [31:0] fill_word(int i);
    return 32'h5A00_0000 ^ (i * 32'h0101_0101) ^ (i << 13);
  endfunction

  function automatic int test_len(int t);
    case (t)
      1:       return 60;
      4:       return 120;
      default: return 40;
    endcase
  endfunction

  function automatic rv_isa_pkg::opcode_t alu_opcode(logic [2:0] k);
    case (k)
      3'd0:    return rv_isa_pkg::OPC_OP;
      3'd1:    return rv_isa_pkg::OPC_OP_IMM;
      3'd2:    return rv_isa_pkg::OPC_LUI;
      3'd3:    return rv_isa_pkg::OPC_AUIPC;
      3'd4:    return rv_isa_pkg::OPC_JAL;
      3'd5:    return rv_isa_pkg::OPC_JALR;
      3'd6:    return rv_isa_pkg::OPC_BRANCH;
      default: return rv_isa_pkg::OPC_MISC_MEM;
    endcase
  endfunction

  task automatic log_error(string msg);
    $display("error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  ////////////////////
  // Stimulus and model
  ////////////////////

  task automatic issue_instr();
    exp_t                e;
    int                  cls;
    int                  o;
    logic                bubble, errb, mis;
    logic [4:0]          rd;
    logic [2:0]          f3;
    logic [1:0]          off;
    logic [7:0]          idx;
    logic [31:0]         r, rs2, w;
    rv_isa_pkg::opcode_t opc;
    // 0 ALU, 1 load, 2 store
    if (cur_test == 0)
      cls = 0;
    else if (cur_test < 4)
      cls = rand_bits(1) ? 1 : 2;
    else
      cls = int'(rand_bits(2) % 3);
    if (cur_test == 5)
      bubble = 1'(rand_bits(1));
    else
      bubble = (cur_test == 4) && (rand_bits(3) == 0);
    if (cur_test == 3)
      errb = 1'(rand_bits(1));
    else
      errb = (cur_test == 4) && (rand_bits(3) == 0);
    rd  = 5'(rand_bits(5));
    off = 2'(rand_bits(2));
    idx = 8'(rand_bits(8));
    rs2 = rand_bits(32);
    r   = rand_bits(32);
    if (cls == 0)
    begin
      opc = alu_opcode(3'(rand_bits(3)));
      f3  = 3'(rand_bits(3));
    end
    else
    begin
      opc = (cls == 1) ? rv_isa_pkg::OPC_LOAD : rv_isa_pkg::OPC_STORE;
      f3  = 3'(rand_bits(2) % 3);
      // Unsigned load variants
      if (cls == 1 && rand_bits(1))
        f3 = (f3 == 3'd2) ? 3'd2 : f3 + 3'd4;
      // Misaligned offsets only in tests 2 and 4
      if (cur_test != 2 && cur_test != 4)
      begin
        if (f3[1:0] == 2'b01)
          off[0] = 1'b0;
        else if (f3[1:0] == 2'b10)
          off = 2'b00;
      end
      r = {21'b0, errb, idx, off};
    end
    mis = (cls != 0) && ((f3[1:0] == 2'b01 && off[0]) || (f3[1:0] == 2'b10 && off != 2'b00));
    e = '{pc: next_pc, exc: '0, addr: r, we: 1'b0, dst: rd, val: r, req: 1'b0};
    if (!bubble)
    begin
      if (cls != 0 && mis)
        e.exc[(cls == 1) ? rv_trap_pkg::CAUSE_MISALIGNED_LOAD
                         : rv_trap_pkg::CAUSE_MISALIGNED_STORE] = 1'b1;
      else if (cls != 0)
      begin
        e.req = 1'b1;
        o = int'(off) * 8;
        if (errb)
          e.exc[(cls == 1) ? rv_trap_pkg::CAUSE_LOAD_ACCESS_FAULT
                           : rv_trap_pkg::CAUSE_STORE_ACCESS_FAULT] = 1'b1;
        else if (cls == 1)
        begin
          w = smem[idx];
          case (f3)
            3'd0:    e.val = {{24{w[o+7]}}, w[o+:8]};
            3'd1:    e.val = {{16{w[o+15]}}, w[o+:16]};
            3'd4:    e.val = {24'b0, w[o+:8]};
            3'd5:    e.val = {16'b0, w[o+:16]};
            default: e.val = w;
          endcase
        end
        else if (f3 == 3'd0)
          smem[idx][o+:8] = rs2[7:0];
        else if (f3 == 3'd1)
          smem[idx][o+:16] = rs2[15:0];
        else
          smem[idx] = rs2;
      end
      e.we = (rd != 5'd0) && (e.exc == '0) && (opc != rv_isa_pkg::OPC_STORE) &&
             (opc != rv_isa_pkg::OPC_BRANCH) && (opc != rv_isa_pkg::OPC_MISC_MEM);
      if (e.we)
        sregs[rd] = e.val;
    end
    ex_pc_i     = next_pc;
    ex_instr_i  = {17'b0, f3, rd, opc, 2'b11};
    ex_bubble_i = bubble;
    ex_r_i      = r;
    ex_rs2_i    = rs2;
    exp_q.push_back(e);
    next_pc = next_pc + 32'd4;
  endtask

  // Oldest instruction leaves write-back
  task automatic retire_check();
    exp_t e;
    e = exp_q.pop_front();
    retired++;
    assert (wb_pc_o == e.pc)
    else log_error($sformatf("retired pc %h, expected %h", wb_pc_o, e.pc));
    assert (wb_exception_o == e.exc)
    else log_error($sformatf("pc %h exception %h, expected %h", e.pc, wb_exception_o, e.exc));
    if (e.exc != '0)
      assert (wb_badaddr_o == e.addr)
      else log_error($sformatf("pc %h bad address %h, expected %h", e.pc, wb_badaddr_o, e.addr));
    if (e.we)
    begin
      rf_raddr_a_i = e.dst;
      chk_val      = e.val;
      chk_pending  = 1'b1;
    end
  endtask

  // Memory responder with 0 to 3 wait cycles
  task automatic respond();
    logic [7:0] idx;
    dmem_ack_i = 1'b0;
    dmem_err_i = 1'b0;
    if (mem_valid)
    begin
      assert (dmem_req_o == exp_q[0].req)
      else log_error($sformatf("pc %h request %b, expected %b", exp_q[0].pc, dmem_req_o,
                               exp_q[0].req));
      if (dmem_req_o)
        assert (dmem_adr_o == {exp_q[0].addr[31:2], 2'b00})
        else log_error($sformatf("address %h, expected %h", dmem_adr_o, exp_q[0].addr));
    end
    else
      assert (!dmem_req_o)
      else log_error("request without an instruction in the memory stage");
    if (!dmem_req_o)
      return;
    if (!busy)
    begin
      busy      = 1'b1;
      wait_left = 2'(rand_bits(2));
    end
    if (wait_left != 2'd0)
    begin
      wait_left--;
      return;
    end
    busy = 1'b0;
    idx  = dmem_adr_o[9:2];
    if (dmem_adr_o[10])
      dmem_err_i = 1'b1;
    else
    begin
      dmem_ack_i = 1'b1;
      dmem_q_i   = resp_mem[idx];
      if (dmem_we_o)
        for (int b = 0; b < 4; b++)
          if (dmem_be_o[b])
            resp_mem[idx][b*8+:8] = dmem_d_o[b*8+:8];
    end
  endtask

  task automatic cycle();
    logic exp_stall;
    @(posedge clk_i);
    #2;
    if (chk_pending)
    begin
      assert (rf_rdata_a_o == chk_val)
      else log_error($sformatf("x%0d holds %h, expected %h", rf_raddr_a_i, rf_rdata_a_o,
                               chk_val));
      chk_pending = 1'b0;
    end
    if (advanced)
    begin
      if (mem_valid)
        retire_check();
      mem_valid = ex_valid;
      ex_valid  = 1'b0;
      ex_bubble_i = 1'b1;
      ex_instr_i  = rv_isa_pkg::instr_nop;
      if (to_issue > 0)
      begin
        issue_instr();
        to_issue--;
        ex_valid = 1'b1;
      end
    end
    respond();
    #1;
    // Pending request without an answer freezes both stages
    exp_stall = 1'b0;
    if (mem_valid)
      exp_stall = exp_q[0].req && !dmem_ack_i && !dmem_err_i;
    assert (stall_o == exp_stall)
    else log_error($sformatf("stall %b, expected %b", stall_o, exp_stall));
    advanced = !stall_o;
  endtask

  task automatic compare_state();
    for (int i = 0; i < `RV_NREGS; i += 2)
    begin
      rf_raddr_a_i = 5'(i);
      rf_raddr_b_i = 5'(i + 1);
      #1;
      assert (rf_rdata_a_o == sregs[i] && rf_rdata_b_o == sregs[i+1])
      else log_error($sformatf("x%0d/x%0d hold %h/%h, expected %h/%h", i, i + 1,
                               rf_rdata_a_o, rf_rdata_b_o, sregs[i], sregs[i+1]));
    end
    for (int i = 0; i < 256; i++)
      assert (resp_mem[i] == smem[i])
      else log_error($sformatf("memory word %0d is %h, expected %h", i, resp_mem[i], smem[i]));
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial
  begin
    int test_errors;
    string names [NUM_TESTS];
    names = '{"alu", "store_load", "misaligned", "bus_error", "random", "bubbles"};
    clk_i = 1'b0;
    rst_ni = 1'b0;
    ex_pc_i = '0;
    ex_instr_i = rv_isa_pkg::instr_nop;
    ex_bubble_i = 1'b1;
    ex_r_i = '0;
    ex_rs2_i = '0;
    dmem_ack_i = 1'b0;
    dmem_err_i = 1'b0;
    dmem_q_i = '0;
    rf_raddr_a_i = '0;
    rf_raddr_b_i = '0;
    lfsr_state = 16'd98;
    next_pc = 32'h1000;
    advanced = 1'b1;
    mem_valid = 1'b0;
    ex_valid = 1'b0;
    chk_pending = 1'b0;
    busy = 1'b0;
    wait_left = '0;
    errors = 0;
    retired = 0;
    for (int i = 0; i < `RV_NREGS; i++)
      sregs[i] = '0;
    for (int i = 0; i < 256; i++)
    begin
      smem[i] = fill_word(i);
      resp_mem[i] = fill_word(i);
    end
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    for (int t = 0; t < NUM_TESTS; t++)
    begin
      test_errors = errors;
      cur_test = t;
      to_issue = test_len(t);
      while (to_issue > 0 || exp_q.size() != 0)
        cycle();
      // Let the last write land
      repeat (3) cycle();
      compare_state();
      $display("test %0d %s: %0d instructions, %0d errors", t, names[t], test_len(t),
               errors - test_errors);
    end
    $display("tests %0d, retired %0d, errors %0d", NUM_TESTS, retired, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  // Up to 6 cycles per instruction plus drain and reset
  initial
  begin
    int budget;
    budget = 20 + NUM_TESTS * 40;
    for (int t = 0; t < NUM_TESTS; t++)
      budget += 6 * test_len(t);
    #(budget * 20);
    $display("watchdog expired before all tests finished");
    $display("** FAIL **");
    $finish;
  end

endmodule

// ==== hw/rv_back_consts.svh ====
////////////////////
// Shared widths and reset values for the RV32I back end
// Only RV32 is supported and XLEN must stay 32
// Register count includes x0, which is hardwired to zero
////////////////////

`ifndef RV_BACK_CONSTS_SVH
`define RV_BACK_CONSTS_SVH

// Data path width
`define RV_XLEN 32

// Instruction word width
`define RV_ILEN 32

// Program counter after reset
`define RV_PC_INIT 'h200

// Integer registers x0..x31
`define RV_NREGS 32

`endif

// ==== hw/rv_back_top.sv ====
////////////////////
// RV32I back end, memory stage to register file
// Execute inputs must hold while stall_o is high
// Memory answers each request with one ack or err
////////////////////

`timescale 1ns/1ns

`include "rv_back_consts.svh"

module rv_back_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Execute side
  input  logic [`RV_XLEN-1:0]           ex_pc_i,
  input  logic [`RV_ILEN-1:0]           ex_instr_i,
  input  logic                          ex_bubble_i,
  input  logic [`RV_XLEN-1:0]           ex_r_i,
  input  logic [`RV_XLEN-1:0]           ex_rs2_i,
  output logic                          stall_o,
  // Data memory
  output logic                          dmem_req_o,
  output logic                          dmem_we_o,
  output logic [`RV_XLEN-1:0]           dmem_adr_o,
  output logic [`RV_XLEN/8-1:0]         dmem_be_o,
  output logic [`RV_XLEN-1:0]           dmem_d_o,
  input  logic                          dmem_ack_i,
  input  logic                          dmem_err_i,
  input  logic [`RV_XLEN-1:0]           dmem_q_i,
  // Register reads
  input  logic [$clog2(`RV_NREGS)-1:0]  rf_raddr_a_i,
  input  logic [$clog2(`RV_NREGS)-1:0]  rf_raddr_b_i,
  output logic [`RV_XLEN-1:0]           rf_rdata_a_o,
  output logic [`RV_XLEN-1:0]           rf_rdata_b_o,
  // Status
  output logic [`RV_XLEN-1:0]           wb_pc_o,
  output rv_trap_pkg::exc_vec_t         wb_exception_o,
  output logic [`RV_XLEN-1:0]           wb_badaddr_o
);

  // Memory stage to write-back
  logic [`RV_XLEN-1:0]          mem_pc;
  logic [`RV_ILEN-1:0]          mem_instr;
  logic                         mem_bubble;
  logic [`RV_XLEN-1:0]          mem_r;
  rv_trap_pkg::exc_vec_t        mem_exception;

  // Write-back to register file
  logic                         wb_we;
  logic [$clog2(`RV_NREGS)-1:0] wb_dst;
  logic [`RV_XLEN-1:0]          wb_r;

  rv_mem_stage u_mem_stage (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .stall_i         (stall_o),
    .ex_pc_i         (ex_pc_i),
    .ex_instr_i      (ex_instr_i),
    .ex_bubble_i     (ex_bubble_i),
    .ex_r_i          (ex_r_i),
    .ex_rs2_i        (ex_rs2_i),
    .mem_pc_o        (mem_pc),
    .mem_instr_o     (mem_instr),
    .mem_bubble_o    (mem_bubble),
    .mem_r_o         (mem_r),
    .mem_exception_o (mem_exception),
    .dmem_req_o      (dmem_req_o),
    .dmem_we_o       (dmem_we_o),
    .dmem_adr_o      (dmem_adr_o),
    .dmem_be_o       (dmem_be_o),
    .dmem_d_o        (dmem_d_o)
  );

  rv_wb_stage u_wb_stage (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .mem_pc_i        (mem_pc),
    .mem_instr_i     (mem_instr),
    .mem_bubble_i    (mem_bubble),
    .mem_r_i         (mem_r),
    .mem_exception_i (mem_exception),
    .dmem_ack_i      (dmem_ack_i),
    .dmem_err_i      (dmem_err_i),
    .dmem_q_i        (dmem_q_i),
    .stall_o         (stall_o),
    .wb_pc_o         (wb_pc_o),
    .wb_exception_o  (wb_exception_o),
    .wb_badaddr_o    (wb_badaddr_o),
    .wb_dst_o        (wb_dst),
    .wb_r_o          (wb_r),
    .wb_we_o         (wb_we)
  );

  rv_regfile u_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .we_i      (wb_we),
    .waddr_i   (wb_dst),
    .wdata_i   (wb_r),
    .raddr_a_i (rf_raddr_a_i),
    .raddr_b_i (rf_raddr_b_i),
    .rdata_a_o (rf_rdata_a_o),
    .rdata_b_o (rf_rdata_b_o)
  );

endmodule

// ==== hw/rv_isa_pkg.sv ====
////////////////////
// RV32I encodings used by the memory and write-back stages
// Only the major opcodes and load/store codes are listed
////////////////////

`include "rv_back_consts.svh"

package rv_isa_pkg;

  ////////////////////
  // Major opcodes
  ////////////////////

  // Instruction bits [6:2]
  typedef enum logic [4:0] {
    OPC_LOAD     = 5'b00000,
    OPC_MISC_MEM = 5'b00011,
    OPC_OP_IMM   = 5'b00100,
    OPC_AUIPC    = 5'b00101,
    OPC_STORE    = 5'b01000,
    OPC_OP       = 5'b01100,
    OPC_LUI      = 5'b01101,
    OPC_BRANCH   = 5'b11000,
    OPC_JALR     = 5'b11001,
    OPC_JAL      = 5'b11011,
    OPC_SYSTEM   = 5'b11100
  } opcode_t;

  ////////////////////
  // Load/store funct3
  ////////////////////

  // Load codes, bit 2 selects zero extension
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } ls_funct3_t;

  // Store codes share the load encodings
  localparam ls_funct3_t SB = LB;
  localparam ls_funct3_t SH = LH;
  localparam ls_funct3_t SW = LW;

  // Access size from funct3[1:0]
  typedef enum logic [1:0] {
    SZ_BYTE   = 2'b00,
    SZ_HALF   = 2'b01,
    SZ_WORD   = 2'b10,
    SZ_DOUBLE = 2'b11
  } ls_size_t;

  // addi x0,x0,0
  localparam logic [`RV_ILEN-1:0] instr_nop = 32'h0000_0013;

endpackage

// ==== hw/rv_load_align.sv ====
////////////////////
// Load data alignment for a 32-bit data bus
// Offset must already be legal for the size
// Unknown funct3 codes pass the raw word
////////////////////

`timescale 1ns/1ns

`include "rv_back_consts.svh"

module rv_load_align (
  input  logic [`RV_XLEN-1:0]    q_i,
  input  logic [1:0]             offset_i,
  input  rv_isa_pkg::ls_funct3_t funct3_i,
  output logic [`RV_XLEN-1:0]    data_o
);

  // Addressed byte moved to lane 0
  logic [`RV_XLEN-1:0] shifted;

  assign shifted = q_i >> {offset_i, 3'b000};

  always_comb
  begin
    case (funct3_i)
      // Signed
      rv_isa_pkg::LB:  data_o = {{(`RV_XLEN-8){shifted[7]}}, shifted[7:0]};
      rv_isa_pkg::LH:  data_o = {{(`RV_XLEN-16){shifted[15]}}, shifted[15:0]};
      rv_isa_pkg::LW:  data_o = shifted;
      // Unsigned
      rv_isa_pkg::LBU: data_o = {{(`RV_XLEN-8){1'b0}}, shifted[7:0]};
      rv_isa_pkg::LHU: data_o = {{(`RV_XLEN-16){1'b0}}, shifted[15:0]};
      default:         data_o = q_i;
    endcase
  end

endmodule

// ==== hw/rv_mem_stage.sv ====
////////////////////
// Memory-access stage of the RV32I back end
// Execute inputs must hold while stall_i is high
// Misaligned accesses raise a cause bit and issue no request
// Request, address and data hold until ack or err
////////////////////

`timescale 1ns/1ns

`include "rv_back_consts.svh"

module rv_mem_stage (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      stall_i,
  input  logic [`RV_XLEN-1:0]       ex_pc_i,
  input  logic [`RV_ILEN-1:0]       ex_instr_i,
  input  logic                      ex_bubble_i,
  input  logic [`RV_XLEN-1:0]       ex_r_i,
  input  logic [`RV_XLEN-1:0]       ex_rs2_i,
  output logic [`RV_XLEN-1:0]       mem_pc_o,
  output logic [`RV_ILEN-1:0]       mem_instr_o,
  output logic                      mem_bubble_o,
  output logic [`RV_XLEN-1:0]       mem_r_o,
  output rv_trap_pkg::exc_vec_t     mem_exception_o,
  output logic                      dmem_req_o,
  output logic                      dmem_we_o,
  output logic [`RV_XLEN-1:0]       dmem_adr_o,
  output logic [`RV_XLEN/8-1:0]     dmem_be_o,
  output logic [`RV_XLEN-1:0]       dmem_d_o
);

  // Store operand alongside mem_r_o
  logic [`RV_XLEN-1:0]  mem_rs2;

  rv_isa_pkg::opcode_t  opcode;
  rv_isa_pkg::ls_size_t size;
  logic [1:0]           offset;
  logic                 is_load;
  logic                 is_store;
  logic                 misaligned;

  ////////////////////
  // Pipeline register
  ////////////////////

  // Control part resets to a bubble
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      mem_pc_o     <= `RV_PC_INIT;
      mem_instr_o  <= rv_isa_pkg::instr_nop;
      mem_bubble_o <= 1'b1;
    end
    else if (!stall_i)
    begin
      mem_pc_o     <= ex_pc_i;
      mem_instr_o  <= ex_instr_i;
      mem_bubble_o <= ex_bubble_i;
    end
  end

  // Operands
  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      mem_r_o <= ex_r_i;
      mem_rs2 <= ex_rs2_i;
    end
  end

  ////////////////////
  // Decode
  ////////////////////

  assign opcode   = rv_isa_pkg::opcode_t'(mem_instr_o[6:2]);
  assign size     = rv_isa_pkg::ls_size_t'(mem_instr_o[13:12]);
  // ALU result is the effective address
  assign offset   = mem_r_o[1:0];
  assign is_load  = !mem_bubble_o && (opcode == rv_isa_pkg::OPC_LOAD);
  assign is_store = !mem_bubble_o && (opcode == rv_isa_pkg::OPC_STORE);

  // Natural alignment per access size
  always_comb
  begin
    case (size)
      rv_isa_pkg::SZ_BYTE: misaligned = 1'b0;
      rv_isa_pkg::SZ_HALF: misaligned = offset[0];
      // Word and the unused RV64 size code
      default:             misaligned = |offset;
    endcase
  end

  always_comb
  begin
    mem_exception_o = '0;
    mem_exception_o[rv_trap_pkg::CAUSE_MISALIGNED_LOAD]  = is_load && misaligned;
    mem_exception_o[rv_trap_pkg::CAUSE_MISALIGNED_STORE] = is_store && misaligned;
  end

  ////////////////////
  // Data-memory request
  ////////////////////

  assign dmem_req_o = (is_load || is_store) && !misaligned;
  assign dmem_we_o  = is_store;
  // Word address with lanes picked by byte enables
  assign dmem_adr_o = {mem_r_o[`RV_XLEN-1:2], 2'b00};

  always_comb
  begin
    case (size)
      rv_isa_pkg::SZ_BYTE:
      begin
        dmem_be_o = 4'b0001 << offset;
        dmem_d_o  = {4{mem_rs2[7:0]}};
      end
      rv_isa_pkg::SZ_HALF:
      begin
        dmem_be_o = 4'b0011 << offset;
        dmem_d_o  = {2{mem_rs2[15:0]}};
      end
      default:
      begin
        dmem_be_o = 4'b1111;
        dmem_d_o  = mem_rs2;
      end
    endcase
  end

  ////////////////////
  // Checks
  ////////////////////

  // A bubble taken from execute never reaches the memory
  a_no_req_on_bubble: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (!stall_i && ex_bubble_i) |=> !dmem_req_o
  );

  // Unanswered request keeps its address and strobe
  a_adr_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (dmem_req_o && stall_i) |=> (dmem_req_o && $stable(dmem_adr_o))
  );

endmodule

// ==== hw/rv_regfile.sv ====
////////////////////
// Integer register file, x1..x31
// One write port, two combinational read ports
// x0 reads as zero and ignores writes
// No write-to-read bypass
////////////////////

`timescale 1ns/1ns

`include "rv_back_consts.svh"

module rv_regfile (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          we_i,
  input  logic [$clog2(`RV_NREGS)-1:0]  waddr_i,
  input  logic [`RV_XLEN-1:0]           wdata_i,
  input  logic [$clog2(`RV_NREGS)-1:0]  raddr_a_i,
  input  logic [$clog2(`RV_NREGS)-1:0]  raddr_b_i,
  output logic [`RV_XLEN-1:0]           rdata_a_o,
  output logic [`RV_XLEN-1:0]           rdata_b_o
);

  // No storage for x0
  logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int i = 1; i < `RV_NREGS; i++)
        regs[i] <= '0;
    end
    else if (we_i && (waddr_i != '0))
      regs[waddr_i] <= wdata_i;
  end

  // Read port A
  always_comb
  begin
    rdata_a_o = '0;
    if (raddr_a_i != '0)
      rdata_a_o = regs[raddr_a_i];
  end

  // Read port B
  always_comb
  begin
    rdata_b_o = '0;
    if (raddr_b_i != '0)
      rdata_b_o = regs[raddr_b_i];
  end

endmodule

// ==== hw/rv_trap_pkg.sv ====
////////////////////
// Exception causes raised by the back end
// Bit positions follow the privileged spec cause codes
// Causes above 15 do not fit the vector
////////////////////

package rv_trap_pkg;

  ////////////////////
  // Cause indices
  ////////////////////

  // Only the data-memory causes are produced here
  typedef enum logic [3:0] {
    CAUSE_MISALIGNED_LOAD     = 4'd4,
    CAUSE_LOAD_ACCESS_FAULT   = 4'd5,
    CAUSE_MISALIGNED_STORE    = 4'd6,
    CAUSE_STORE_ACCESS_FAULT  = 4'd7
  } cause_e;

  ////////////////////
  // Exception vector
  ////////////////////

  // One bit per cause, indexed by cause_e
  typedef logic [15:0] exc_vec_t;

endpackage

// ==== hw/rv_wb_stage.sv ====
////////////////////
// Write-back stage of the RV32I back end
// Stall is combinational from dmem_ack_i and dmem_err_i
// wb_we_o pulses once per instruction
// Other outputs hold through a stall
////////////////////

`timescale 1ns/1ns

`include "rv_back_consts.svh"

module rv_wb_stage (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic [`RV_XLEN-1:0]               mem_pc_i,
  input  logic [`RV_ILEN-1:0]               mem_instr_i,
  input  logic                              mem_bubble_i,
  input  logic [`RV_XLEN-1:0]               mem_r_i,
  input  rv_trap_pkg::exc_vec_t             mem_exception_i,
  input  logic                              dmem_ack_i,
  input  logic                              dmem_err_i,
  input  logic [`RV_XLEN-1:0]               dmem_q_i,
  output logic                              stall_o,
  output logic [`RV_XLEN-1:0]               wb_pc_o,
  output rv_trap_pkg::exc_vec_t             wb_exception_o,
  output logic [`RV_XLEN-1:0]               wb_badaddr_o,
  output logic [$clog2(`RV_NREGS)-1:0]      wb_dst_o,
  output logic [`RV_XLEN-1:0]               wb_r_o,
  output logic                              wb_we_o
);

  rv_isa_pkg::opcode_t              opcode;
  rv_isa_pkg::ls_funct3_t           funct3;
  logic [$clog2(`RV_NREGS)-1:0]     dst;
  logic                             is_load;
  logic                             is_store;
  // Request went out for this instruction
  logic                             issued;
  rv_trap_pkg::exc_vec_t            exception;
  logic [`RV_XLEN-1:0]              load_data;
  logic                             we_cond;

  ////////////////////
  // Decode
  ////////////////////

  assign opcode   = rv_isa_pkg::opcode_t'(mem_instr_i[6:2]);
  assign funct3   = rv_isa_pkg::ls_funct3_t'(mem_instr_i[14:12]);
  assign dst      = mem_instr_i[11:7];
  assign is_load  = !mem_bubble_i && (opcode == rv_isa_pkg::OPC_LOAD);
  assign is_store = !mem_bubble_i && (opcode == rv_isa_pkg::OPC_STORE);
  // Misaligned accesses never reach memory
  assign issued   = (is_load || is_store) && !(|mem_exception_i);

  // Wait for the answer
  assign stall_o = issued && !(dmem_ack_i || dmem_err_i);

  ////////////////////
  // Exceptions
  ////////////////////

  // Bus error becomes an access fault
  always_comb
  begin
    exception = mem_exception_i;
    if (issued && dmem_err_i)
    begin
      if (is_load)
        exception[rv_trap_pkg::CAUSE_LOAD_ACCESS_FAULT] = 1'b1;
      else
        exception[rv_trap_pkg::CAUSE_STORE_ACCESS_FAULT] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wb_pc_o        <= `RV_PC_INIT;
      wb_exception_o <= '0;
    end
    else if (!stall_o)
    begin
      wb_pc_o        <= mem_pc_i;
      wb_exception_o <= exception;
    end
  end

  // Faulting data address, else the pc
  always_ff @(posedge clk_i)
  begin
    if (!stall_o)
      wb_badaddr_o <= (|exception) ? mem_r_i : mem_pc_i;
  end

  ////////////////////
  // Register write
  ////////////////////

  rv_load_align u_load_align (
    .q_i      (dmem_q_i),
    .offset_i (mem_r_i[1:0]),
    .funct3_i (funct3),
    .data_o   (load_data)
  );

  // No write for x0, stores, branches, fences or faults
  always_comb
  begin
    we_cond = !mem_bubble_i && (dst != '0) && !(|exception);
    case (opcode)
      rv_isa_pkg::OPC_STORE,
      rv_isa_pkg::OPC_BRANCH,
      rv_isa_pkg::OPC_MISC_MEM: we_cond = 1'b0;
      default:                  ;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!stall_o)
    begin
      wb_dst_o <= dst;
      wb_r_o   <= is_load ? load_data : mem_r_i;
    end
  end

  // Low during a stall, so each result is written once
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      wb_we_o <= 1'b0;
    else
      wb_we_o <= we_cond && !stall_o;
  end

  ////////////////////
  // Checks
  ////////////////////

  // Memory answers with one strobe only
  a_ack_err_excl: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(dmem_ack_i && dmem_err_i)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the back-end testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing --assert -f rv_back.f \
    --top-module tb_rv_back -Mdir obj_dir; then
  echo "compile failed"
  exit 1
fi

if ! ./obj_dir/Vtb_rv_back > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error"
  exit 1
fi

cat "$LOG"
if grep -qxF '** PASS **' "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== rv_back.f ====
+incdir+hw
hw/rv_isa_pkg.sv
hw/rv_trap_pkg.sv
hw/rv_mem_stage.sv
hw/rv_load_align.sv
hw/rv_wb_stage.sv
hw/rv_regfile.sv
hw/rv_back_top.sv
bench/tb_rv_back.sv
